//--- design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // ************************************************************
    // widths
    // ************************************************************
    localparam int xlen      = 64;  // data and address
    localparam int inst_w    = 32;
    localparam int reg_idx_w = 5;
    localparam int strb_w    = xlen / 8;  // bytes per word

    // instruction field positions
    localparam int rd_lsb  = 7;   // rd is inst[11:7]
    localparam int rs2_lsb = 20;  // rs2 is inst[24:20]

    typedef logic [xlen-1:0]      xlen_t;
    typedef logic [inst_w-1:0]    inst_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [strb_w-1:0]    strb_t;

    // ************************************************************
    // operation carried down from decode
    // ************************************************************
    typedef enum logic [4:0] {
        op_none,  // bubble or no write
        op_alu,
        op_link,  // jal / jalr, rd = pc + 4
        op_csr,   // old csr value rides on src2
        op_lb,
        op_lh,
        op_lw,
        op_ld,
        op_lbu,
        op_lhu,
        op_lwu,
        op_sb,
        op_sh,
        op_sw,
        op_sd
    } mem_op_t;

    function automatic logic is_load(mem_op_t op);
        return op inside {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    endfunction

    function automatic logic is_store(mem_op_t op);
        return op inside {op_sb, op_sh, op_sw, op_sd};
    endfunction

    // bytes touched by a memory op, 0 for everything else
    function automatic logic [3:0] access_bytes(mem_op_t op);
        case (op)
            op_lb, op_lbu, op_sb: return 4'd1;
            op_lh, op_lhu, op_sh: return 4'd2;
            op_lw, op_lwu, op_sw: return 4'd4;
            op_ld, op_sd:         return 4'd8;
            default:              return 4'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- design/store_unit.sv
`default_nettype none

module store_unit
    import lsu_pkg::*;
(
    input  mem_op_t  op,
    input  xlen_t    addr,
    input  xlen_t    src2,      // rs2 value read back in decode
    input  reg_idx_t rs2,
    input  logic     wb_valid,
    input  logic     wb_wen,
    input  reg_idx_t wb_rd,
    input  xlen_t    wb_wdata,
    output xlen_t    wdata,     // lane aligned
    output strb_t    wmask
);

    logic       fwd_hit;
    xlen_t      sdata;
    logic [3:0] nbytes;
    logic [5:0] shamt;      // lane in bits
    strb_t      base_mask;  // low nbytes set
    xlen_t      keep_bits;

    // wb writes rs2 this cycle, so src2 is stale. x0 never forwards
    assign fwd_hit = wb_valid && wb_wen && (wb_rd != '0) && (wb_rd == rs2);
    assign sdata   = fwd_hit ? wb_wdata : src2;

    assign nbytes = access_bytes(op);
    assign shamt  = {addr[2:0], 3'b000};

    always_comb begin
        // 9 bits wide so that 8 bytes gives 8'hff
        base_mask = strb_t'((9'd1 << nbytes) - 9'd1);

        for (int i = 0; i < strb_w; i++) begin
            keep_bits[8*i +: 8] = {8{base_mask[i]}};
        end

        if (is_store(op)) begin
            wdata = (sdata & keep_bits) << shamt;
            wmask = base_mask << addr[2:0];  // bytes past lane 7 drop off
        end else begin
            wdata = '0;
            wmask = '0;
        end
    end

endmodule

`default_nettype wire

//--- design/load_unit.sv
`default_nettype none

module load_unit
    import lsu_pkg::*;
(
    input  mem_op_t op,
    input  xlen_t   addr,
    input  xlen_t   rdata,  // whole ram word
    output xlen_t   ldata
);

    logic [5:0] shamt;
    xlen_t      lane_data;  // addressed byte moved down to bit 0

    assign shamt     = {addr[2:0], 3'b000};
    assign lane_data = rdata >> shamt;

    // ************************************************************
    // size select and extension
    // ************************************************************
    always_comb begin
        case (op)
            op_lb: begin
                ldata = {{(xlen-8){lane_data[7]}}, lane_data[7:0]};
            end
            op_lh: begin
                ldata = {{(xlen-16){lane_data[15]}}, lane_data[15:0]};
            end
            op_lw: begin
                ldata = {{(xlen-32){lane_data[31]}}, lane_data[31:0]};
            end
            op_lbu:  ldata = {{(xlen-8){1'b0}}, lane_data[7:0]};
            op_lhu:  ldata = {{(xlen-16){1'b0}}, lane_data[15:0]};
            op_lwu:  ldata = {{(xlen-32){1'b0}}, lane_data[31:0]};
            op_ld:   ldata = lane_data;  // aligned, lane 0
            default: ldata = '0;         // not a load
        endcase
    end

endmodule

`default_nettype wire

//--- design/data_ram.sv
`default_nettype none

module data_ram
    import lsu_pkg::*;
#(
    parameter int ram_depth_log2 = 10
) (
    input  logic  clk,
    input  xlen_t addr,   // byte address, low 3 bits pick the lane
    output xlen_t rdata,
    input  logic  we,
    input  xlen_t wdata,
    input  strb_t wmask
);

    localparam int depth = 2 ** ram_depth_log2;

    xlen_t mem [depth];

    logic [ram_depth_log2-1:0] word_idx;

    // upper address bits ignored, accesses wrap
    assign word_idx = addr[3 +: ram_depth_log2];

    assign rdata = mem[word_idx];  // async read

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < strb_w; i++) begin
                if (wmask[i]) begin
                    mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/wb_select.sv
`default_nettype none

module wb_select
    import lsu_pkg::*;
(
    input  mem_op_t op,
    input  xlen_t   pc,
    input  xlen_t   alu_result,
    input  xlen_t   src2,    // csr old value, never forwarded
    input  xlen_t   ldata,
    output logic    wen,
    output xlen_t   wdata
);

    always_comb begin
        wen   = 1'b1;
        wdata = '0;
        if (is_load(op)) begin
            wdata = ldata;
        end else begin
            case (op)
                op_alu:  wdata = alu_result;
                op_link: wdata = pc + xlen_t'(4);  // return address
                op_csr:  wdata = src2;
                default: wen   = 1'b0;             // stores and bubbles
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/mem_stage.sv
`default_nettype none

module mem_stage
    import lsu_pkg::*;
#(
    parameter int ram_depth_log2 = 10  // ram words = 2**ram_depth_log2
) (
    input  logic     clk,
    input  logic     rst,
    // from execute
    input  logic     in_valid,
    output logic     in_ready,
    input  xlen_t    in_pc,
    input  inst_t    in_inst,
    input  mem_op_t  in_op,
    input  xlen_t    in_alu_result,
    input  xlen_t    in_src2,
    // to write-back
    output logic     out_valid,
    input  logic     out_ready,
    output xlen_t    out_pc,
    output inst_t    out_inst,
    output logic     rf_wen,
    output reg_idx_t rf_rd,
    output xlen_t    rf_wdata,
    // write-back stage, for store data forwarding
    input  logic     wb_valid,
    input  logic     wb_wen,
    input  reg_idx_t wb_rd,
    input  xlen_t    wb_wdata
);

    // ************************************************************
    // pipeline register
    // ************************************************************
    logic    r_valid;
    xlen_t   r_pc;
    inst_t   r_inst;
    mem_op_t r_op;
    xlen_t   r_alu;   // also the byte address for loads/stores
    xlen_t   r_src2;

    assign in_ready = out_ready;  // single slot, moves only when wb takes it

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid <= 1'b0;
            r_pc    <= '0;
            r_inst  <= '0;
            r_op    <= op_none;
            r_alu   <= '0;
            r_src2  <= '0;
        end else if (in_ready) begin
            r_valid <= in_valid;  // bubble when ex has nothing
            r_pc    <= in_pc;
            r_inst  <= in_inst;
            r_op    <= in_op;
            r_alu   <= in_alu_result;
            r_src2  <= in_src2;
        end
        // stalled: hold everything
    end

    mem_op_t  op_eff;  // op_none while empty
    reg_idx_t rs2;
    xlen_t    st_wdata;
    strb_t    st_wmask;
    xlen_t    ram_rdata;
    logic     ram_we;
    xlen_t    ld_data;

    assign op_eff = r_valid ? r_op : op_none;
    assign rs2    = r_inst[rs2_lsb +: reg_idx_w];

    // write only on the edge the store leaves, so a stall never repeats it
    assign ram_we = r_valid && out_ready && is_store(op_eff);

    // ************************************************************
    // datapath
    // ************************************************************
    store_unit store_unit_inst (
        .op       (op_eff),
        .addr     (r_alu),
        .src2     (r_src2),
        .rs2      (rs2),
        .wb_valid (wb_valid),
        .wb_wen   (wb_wen),
        .wb_rd    (wb_rd),
        .wb_wdata (wb_wdata),
        .wdata    (st_wdata),
        .wmask    (st_wmask)
    );

    data_ram #(
        .ram_depth_log2 (ram_depth_log2)
    ) data_ram_inst (
        .clk   (clk),
        .addr  (r_alu),
        .rdata (ram_rdata),
        .we    (ram_we),
        .wdata (st_wdata),
        .wmask (st_wmask)
    );

    load_unit load_unit_inst (
        .op    (op_eff),
        .addr  (r_alu),
        .rdata (ram_rdata),
        .ldata (ld_data)
    );

    wb_select wb_select_inst (
        .op         (op_eff),
        .pc         (r_pc),
        .alu_result (r_alu),
        .src2       (r_src2),
        .ldata      (ld_data),
        .wen        (rf_wen),
        .wdata      (rf_wdata)
    );

    assign out_valid = r_valid;
    assign out_pc    = r_pc;
    assign out_inst  = r_inst;
    assign rf_rd     = r_valid ? r_inst[rd_lsb +: reg_idx_w] : '0;

endmodule

`default_nettype wire

//--- include/tb_model.svh
`ifndef tb_model_svh
`define tb_model_svh

// shadow of the data ram, one entry per byte address
byte unsigned model_mem [lsu_pkg::xlen_t];

// record a store that left the stage, data already forwarded
function automatic void model_store(lsu_pkg::mem_op_t op, lsu_pkg::xlen_t addr,
                                    lsu_pkg::xlen_t data);
    int unsigned n;
    n = lsu_pkg::access_bytes(op);
    for (int unsigned i = 0; i < n; i++) begin
        model_mem[addr + i] = data[8*i +: 8];
    end
endfunction

// expected load result, little endian then extended
function automatic lsu_pkg::xlen_t model_load(lsu_pkg::mem_op_t op, lsu_pkg::xlen_t addr);
    lsu_pkg::xlen_t raw;
    int unsigned    n;
    raw = '0;
    n   = lsu_pkg::access_bytes(op);
    for (int unsigned i = 0; i < n; i++) begin
        if (model_mem.exists(addr + i)) begin
            raw[8*i +: 8] = model_mem[addr + i];
        end
    end
    case (op)
        lsu_pkg::op_lb: return {{56{raw[7]}}, raw[7:0]};
        lsu_pkg::op_lh: return {{48{raw[15]}}, raw[15:0]};
        lsu_pkg::op_lw: return {{32{raw[31]}}, raw[31:0]};
        default:        return raw;  // unsigned kinds and ld
    endcase
endfunction

// expected register write, wen then value
function automatic bit model_wen(lsu_pkg::mem_op_t op);
    return lsu_pkg::is_load(op) || op inside {lsu_pkg::op_alu, lsu_pkg::op_link,
                                              lsu_pkg::op_csr};
endfunction

function automatic lsu_pkg::xlen_t model_wb(lsu_pkg::mem_op_t op, lsu_pkg::xlen_t pc,
                                            lsu_pkg::xlen_t alu, lsu_pkg::xlen_t src2,
                                            lsu_pkg::xlen_t addr);
    if (lsu_pkg::is_load(op)) return model_load(op, addr);
    case (op)
        lsu_pkg::op_alu:  return alu;
        lsu_pkg::op_link: return pc + 64'd4;
        lsu_pkg::op_csr:  return src2;
        default:          return '0;
    endcase
endfunction

`endif

//--- tb/tb_mem_stage.sv
`default_nettype none

module tb_mem_stage
    import lsu_pkg::*;
();

    logic     clk;
    logic     rst;
    logic     in_valid;
    logic     in_ready;
    xlen_t    in_pc;
    inst_t    in_inst;
    mem_op_t  in_op;
    xlen_t    in_alu_result;
    xlen_t    in_src2;
    logic     out_valid;
    logic     out_ready;
    xlen_t    out_pc;
    inst_t    out_inst;
    logic     rf_wen;
    reg_idx_t rf_rd;
    xlen_t    rf_wdata;
    logic     wb_valid;
    logic     wb_wen;
    reg_idx_t wb_rd;
    xlen_t    wb_wdata;

    mem_op_t st_ops [4] = '{op_sb, op_sh, op_sw, op_sd};
    mem_op_t ld_ops [7] = '{op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};

    `include "tb_model.svh"

    mem_stage #(.ram_depth_log2(10)) mem_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // period 40
    end

    // ************************************************************
    // helpers
    // ************************************************************
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        assert (got === exp) else fail_run($sformatf("MISMATCH time=%0t %s got=%h exp=%h",
                                                     $time, name, got, exp));
    endtask

    function automatic xlen_t rand64();
        return {$urandom, $urandom};
    endfunction

    // byte address inside the first 16 words, aligned to the access size
    function automatic xlen_t pick_addr(mem_op_t op, int unsigned word);
        int unsigned sz;
        sz = access_bytes(op);
        return xlen_t'(word * 8 + ($urandom % (8 / sz)) * sz);
    endfunction

    // hand one item to the stage, check it one cycle later, optionally stall it
    task automatic send_item(input mem_op_t op, input xlen_t alu, input xlen_t src2,
                             input reg_idx_t rs2, input logic fv, input logic fw,
                             input reg_idx_t frd, input xlen_t fdata, input int stall);
        xlen_t pc;
        inst_t inst;
        xlen_t exp_wd;
        int    n;
        pc   = {32'h0, $urandom} & ~xlen_t'(3);
        inst = $urandom;
        inst[rs2_lsb +: reg_idx_w] = rs2;  // forwarding compares against this field
        in_valid      = 1'b1;
        in_pc         = pc;
        in_inst       = inst;
        in_op         = op;
        in_alu_result = alu;
        in_src2       = src2;
        out_ready     = 1'b1;
        n = 0;
        while (!in_ready) begin
            @(posedge clk);
            #2;
            n++;
            if (n > 20) fail_run("timeout waiting for in_ready to rise");
        end
        @(posedge clk);  // accepted here
        #2;
        in_valid = 1'b0;
        wb_valid = fv;   // seen by the store while it sits in the stage
        wb_wen   = fw;
        wb_rd    = frd;
        wb_wdata = fdata;
        exp_wd = model_wb(op, pc, alu, src2, alu);
        check_value("out_valid", out_valid, 64'd1);
        check_value("out_pc", out_pc, pc);
        check_value("out_inst", out_inst, inst);
        check_value("rf_rd", rf_rd, inst[rd_lsb +: reg_idx_w]);
        check_value("rf_wen", rf_wen, model_wen(op));
        check_value("rf_wdata", rf_wdata, exp_wd);
        if (is_store(op)) begin
            model_store(op, alu, (fv && fw && frd != 0 && frd == rs2) ? fdata : src2);
        end
        if (stall > 0) begin
            out_ready = 1'b0;
            repeat (stall) begin
                @(posedge clk);
                #2;
                check_value("in_ready", in_ready, 64'd0);
                check_value("out_pc", out_pc, pc);
                check_value("rf_wdata", rf_wdata, exp_wd);
            end
            out_ready = 1'b1;
        end
    endtask

    // ************************************************************
    // held outputs under back-pressure
    // ************************************************************
    assert property (@(posedge clk) in_ready == out_ready)
        else fail_run("in_ready does not follow out_ready");

    assert property (@(posedge clk) disable iff (rst) !out_ready |=> $stable(out_valid) &&
                     $stable(out_pc) && $stable(out_inst) && $stable(rf_wen) &&
                     $stable(rf_rd) && $stable(rf_wdata))
        else fail_run("outputs changed while out_ready was low");

    // ************************************************************
    // stimulus
    // ************************************************************
    initial begin
        mem_op_t op;
        int      stall;
        xlen_t   src;
        void'($urandom(32'he57fcb38));
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_pc         = '0;
        in_inst       = '0;
        in_op         = op_none;
        in_alu_result = '0;
        in_src2       = '0;
        out_ready     = 1'b1;
        wb_valid      = 1'b0;
        wb_wen        = 1'b0;
        wb_rd         = '0;
        wb_wdata      = '0;
        repeat (3) begin
            @(posedge clk);
            #2;
            check_value("out_valid", out_valid, 64'd0);
            check_value("rf_wen", rf_wen, 64'd0);
        end
        rst = 1'b0;  // three edges in reset
        repeat (2) begin
            @(posedge clk);
            #2;
            check_value("out_valid", out_valid, 64'd0);  // idle, nothing sent yet
            check_value("rf_wen", rf_wen, 64'd0);
        end
        for (int i = 0; i < 16; i++) begin
            send_item(op_sd, xlen_t'(i * 8), rand64(), 0, 0, 0, 0, 0, 0);
        end
        // random stores, then loads at lanes of the same word
        for (int k = 0; k < 40; k++) begin
            op    = st_ops[$urandom % 4];
            stall = ($urandom % 4 == 0) ? 1 + $urandom % 4 : 0;
            src   = pick_addr(op, $urandom % 16);
            send_item(op, src, rand64(), 0, 0, 0, 0, 0, stall);
            repeat (3) begin
                op = ld_ops[$urandom % 7];
                send_item(op, pick_addr(op, src[6:3]), rand64(), 0, 0, 0, 0, 0, $urandom % 2);
            end
        end
        // non-memory write-back
        send_item(op_alu, rand64(), rand64(), 0, 0, 0, 0, 0, 0);
        send_item(op_link, rand64(), rand64(), 0, 0, 0, 0, 0, 0);
        send_item(op_csr, rand64(), rand64(), 0, 0, 0, 0, 0, 0);
        send_item(op_none, rand64(), rand64(), 0, 0, 0, 0, 0, 0);
        // forwarding hit, then x0 and wen low both fall back to src2
        send_item(op_sd, 64'd24, rand64(), 5'd9, 1, 1, 5'd9, rand64(), 0);
        send_item(op_ld, 64'd24, 0, 0, 0, 0, 0, 0, 0);
        send_item(op_sd, 64'd32, rand64(), 5'd0, 1, 1, 5'd0, rand64(), 0);
        send_item(op_ld, 64'd32, 0, 0, 0, 0, 0, 0, 0);
        send_item(op_sd, 64'd40, rand64(), 5'd12, 1, 0, 5'd12, rand64(), 0);
        send_item(op_ld, 64'd40, 0, 0, 0, 0, 0, 0, 0);
        // stalled byte store, written once, neighbour store keeps it
        send_item(op_sb, 64'd51, rand64(), 0, 0, 0, 0, 0, 6);
        send_item(op_lbu, 64'd51, 0, 0, 0, 0, 0, 0, 0);
        send_item(op_sb, 64'd50, rand64(), 0, 0, 0, 0, 0, 0);
        send_item(op_lhu, 64'd50, 0, 0, 0, 0, 0, 0, 3);
        @(posedge clk);
        #2;
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
design/lsu_pkg.sv
design/store_unit.sv
design/load_unit.sv
design/data_ram.sv
design/wb_select.sv
design/mem_stage.sv
tb/tb_mem_stage.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the mem_stage testbench with Verilator
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -Wno-fatal \
        -f tb.f --top-module tb_mem_stage -o sim_mem_stage &&
    ./obj_dir/sim_mem_stage ||
    {
        echo "simulation did not pass"
        exit 1
    }
